//--- hdl/csc_types_pkg.sv
// ******************************
// Pixel, sync and term types shared by the converter pipeline
// Terms are sign-magnitude, scaled by 4096
// ******************************
`default_nettype none

package csc_types_pkg;

  // Component and term widths
  localparam int CHAN_W = 8;
  localparam int MAG_W  = 24;
  localparam int TERM_W = MAG_W + 1;

  // One colour, luma or chroma component
  typedef logic [CHAN_W-1:0] chan_t;

  // Unsigned product magnitude, 8 bit colour times 16 bit coefficient
  typedef logic [MAG_W-1:0] mag_t;

  // Sign bit on top, magnitude below
  typedef logic [TERM_W-1:0] term_t;

  // R,G,B on the input side, Y,Cb,Cr on the output side
  typedef struct packed {
    chan_t c0;
    chan_t c1;
    chan_t c2;
  } pixel_t;

  // Video timing levels, carried next to the data
  typedef struct packed {
    logic valid;
    logic hsync;
    logic vsync;
  } sync_t;

  // Everything one output channel needs from the input side
  typedef struct packed {
    term_t prod_c0;
    term_t prod_c1;
    term_t prod_c2;
    term_t offset;
  } term_set_t;

  // Delay-data width of the adders
  localparam int SYNC_W = $bits(sync_t);

  // Pipeline depths
  localparam int ADDER_LATENCY = 4;
  // Product register plus adder plus output register
  localparam int CSC_LATENCY   = ADDER_LATENCY + 2;

endpackage

`default_nettype wire

//--- hdl/csc_coef_pkg.sv
// ******************************
// Full-range BT.601 coefficients, fixed at build time
// ******************************
`default_nettype none

package csc_coef_pkg;

  import csc_types_pkg::*;

  // Fixed-point scale, 1.0 is 4096
  localparam int FRAC_BITS  = 12;
  localparam int COEF_MAG_W = 16;

  // Matrix shape
  localparam int NUM_ROWS = 3;
  localparam int NUM_CHAN = 3;

  // Row order of the matrix and offsets
  localparam int ROW_Y  = 0;
  localparam int ROW_CB = 1;
  localparam int ROW_CR = 2;

  // Sign on top, 16 bit magnitude with 12 fraction bits
  typedef logic [COEF_MAG_W:0] coef_t;

  // Columns are R, G, B
  localparam coef_t CSC_COEF [NUM_ROWS][NUM_CHAN] = '{
    '{ {1'b0, 16'd1225}, {1'b0, 16'd2404}, {1'b0, 16'd467}  },
    '{ {1'b1, 16'd691},  {1'b1, 16'd1357}, {1'b0, 16'd2048} },
    '{ {1'b0, 16'd2048}, {1'b1, 16'd1715}, {1'b1, 16'd333}  }
  };

  // Chroma midpoint, 128 at the output scale
  localparam mag_t CHROMA_MID = 24'd128 << FRAC_BITS;

  // Offset term per row, always positive
  localparam term_t CSC_OFFSET [NUM_ROWS] = '{
    {1'b0, 24'd0},
    {1'b0, CHROMA_MID},
    {1'b0, CHROMA_MID}
  };

endpackage

`default_nettype wire

//--- hdl/csc_products.sv
// ******************************
// One register stage, no handshake
// Colour inputs are treated as unsigned
// ******************************
`timescale 1ns/1ps
`default_nettype none

module csc_products
  import csc_types_pkg::*;
  import csc_coef_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  pixel_t    pixel_in,
  input  sync_t     sync_in,
  output term_set_t terms_y,
  output term_set_t terms_cb,
  output term_set_t terms_cr,
  output sync_t     sync_q
);

  // Colour times coefficient magnitude, sign taken from the coefficient
  function automatic term_t scale_term(input chan_t colour, input coef_t coef);
    mag_t mag;
    mag = colour * coef[COEF_MAG_W-1:0];
    return {coef[COEF_MAG_W], mag};
  endfunction

  chan_t     colour  [NUM_CHAN];
  term_set_t terms_d [NUM_ROWS];
  term_set_t terms_q [NUM_ROWS];

  // R, G, B in matrix column order
  assign colour[0] = pixel_in.c0;
  assign colour[1] = pixel_in.c1;
  assign colour[2] = pixel_in.c2;

  // Nine products and three offsets
  always_comb begin
    for (int row = 0; row < NUM_ROWS; row++) begin
      terms_d[row].prod_c0 = scale_term(colour[0], CSC_COEF[row][0]);
      terms_d[row].prod_c1 = scale_term(colour[1], CSC_COEF[row][1]);
      terms_d[row].prod_c2 = scale_term(colour[2], CSC_COEF[row][2]);
      // Offset rides along as the fourth adder input
      terms_d[row].offset  = CSC_OFFSET[row];
    end
  end

  // Term registers, payload only
  always_ff @(posedge clk) begin
    for (int row = 0; row < NUM_ROWS; row++) begin
      terms_q[row] <= terms_d[row];
    end
  end

  // Sync word stays aligned with the terms
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q <= '0;
    end else begin
      sync_q <= sync_in;
    end
  end

  assign terms_y  = terms_q[ROW_Y];
  assign terms_cb = terms_q[ROW_CB];
  assign terms_cr = terms_q[ROW_CR];

  // A pixel marked valid must have come from known colour inputs
  a_terms_known: assert property (
    @(posedge clk) disable iff (reset)
    sync_q.valid |-> !$isunknown({terms_y, terms_cb, terms_cr})
  ) else $error("products: unknown term on a valid pixel");

endmodule

`default_nettype wire

//--- hdl/four_input_signed_adder.sv
// ******************************
// Sum wraps modulo 2^25, result truncated, not rounded
// Output saturates to 0..255 at the 4096 scale
// ******************************
`timescale 1ns/1ps
`default_nettype none

module four_input_signed_adder
  import csc_types_pkg::*;
  import csc_coef_pkg::*;
#(
  parameter int DELAY_DATA_WIDTH = SYNC_W
) (
  input  logic                        clk,
  input  logic                        reset,
  input  term_t                       data_1,
  input  term_t                       data_2,
  input  term_t                       data_3,
  input  term_t                       data_4,
  input  logic [DELAY_DATA_WIDTH-1:0] ddata_in,
  output chan_t                       data_p,
  output logic [DELAY_DATA_WIDTH-1:0] ddata_out
);

  localparam int HIST_W = $clog2(ADDER_LATENCY + 1);

  // Sign-magnitude to two's complement
  function automatic term_t to_twos(input term_t t);
    term_t mag;
    mag = {1'b0, t[MAG_W-1:0]};
    return t[TERM_W-1] ? term_t'(-mag) : mag;
  endfunction

  // Negative clamps to 0, anything above 255.x clamps to 255
  function automatic chan_t saturate(input term_t s);
    if (s[TERM_W-1]) begin
      return '0;
    end
    if (|s[MAG_W-1:FRAC_BITS+CHAN_W]) begin
      return '1;
    end
    return s[FRAC_BITS +: CHAN_W];
  endfunction

  term_t tc_q [4];
  term_t pair_a_q;
  term_t pair_b_q;
  term_t sum_q;

  logic [DELAY_DATA_WIDTH-1:0] ddata_q [ADDER_LATENCY];

  logic [HIST_W-1:0] hist_cnt;
  logic              hist_ok;

  // Data pipeline, four stages
  always_ff @(posedge clk) begin
    // Stage 1
    tc_q[0]  <= to_twos(data_1);
    tc_q[1]  <= to_twos(data_2);
    tc_q[2]  <= to_twos(data_3);
    tc_q[3]  <= to_twos(data_4);
    // Stage 2, pairwise sums
    pair_a_q <= tc_q[0] + tc_q[1];
    pair_b_q <= tc_q[2] + tc_q[3];
    // Stage 3, carry out of bit 24 is dropped
    sum_q    <= pair_a_q + pair_b_q;
    // Stage 4
    data_p   <= saturate(sum_q);
  end

  // Delay data, same depth as the data path
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ADDER_LATENCY; i++) begin
        ddata_q[i] <= '0;
      end
    end else begin
      ddata_q[0] <= ddata_in;
      for (int i = 1; i < ADDER_LATENCY; i++) begin
        ddata_q[i] <= ddata_q[i-1];
      end
    end
  end

  assign ddata_out = ddata_q[ADDER_LATENCY-1];

  // Cycles since reset, saturating at the pipeline depth
  always_ff @(posedge clk) begin
    if (reset) begin
      hist_cnt <= '0;
    end else if (!hist_ok) begin
      hist_cnt <= hist_cnt + 1'b1;
    end
  end

  assign hist_ok = (hist_cnt == HIST_W'(ADDER_LATENCY));

  // Delay data leaves exactly one pipeline depth after it entered
  a_ddata_latency: assert property (
    @(posedge clk) disable iff (reset)
    hist_ok |-> ddata_out == $past(ddata_in, ADDER_LATENCY)
  ) else $error("adder: ddata_out lost alignment with ddata_in");

  // Once the pipeline has filled, outputs are known
  a_no_x_out: assert property (
    @(posedge clk) disable iff (reset)
    hist_ok |-> !$isunknown({data_p, ddata_out})
  ) else $error("adder: unknown value on outputs");

endmodule

`default_nettype wire

//--- hdl/csc_pixel_out.sv
// ******************************
// Blanks on valid from the Y channel
// ******************************
`timescale 1ns/1ps
`default_nettype none

module csc_pixel_out
  import csc_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  chan_t  y,
  input  chan_t  cb,
  input  chan_t  cr,
  input  sync_t  sync_y,
  input  sync_t  sync_cb,
  input  sync_t  sync_cr,
  output pixel_t pixel_out,
  output sync_t  sync_out
);

  // Packed pixel, zero during blanking
  always_ff @(posedge clk) begin
    if (sync_y.valid) begin
      pixel_out.c0 <= y;
      pixel_out.c1 <= cb;
      pixel_out.c2 <= cr;
    end else begin
      pixel_out <= '0;
    end
  end

  // Sync levels leave together with the pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_out <= '0;
    end else begin
      sync_out <= sync_y;
    end
  end

  // All three adders carry the same sync word in lock step
  a_sync_agree: assert property (
    @(posedge clk) disable iff (reset)
    (sync_cb == sync_y) && (sync_cr == sync_y)
  ) else $error("pixel_out: channel sync words disagree");

endmodule

`default_nettype wire

//--- hdl/csc_rgb2ycbcr.sv
// ******************************
// RGB to YCbCr, six cycle latency
// One pixel per clock, no back-pressure
// ******************************
`timescale 1ns/1ps
`default_nettype none

module csc_rgb2ycbcr
  import csc_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  pixel_t pixel_in,
  input  sync_t  sync_in,
  output pixel_t pixel_out,
  output sync_t  sync_out
);

  term_set_t terms_y;
  term_set_t terms_cb;
  term_set_t terms_cr;
  sync_t     sync_q;

  chan_t y;
  chan_t cb;
  chan_t cr;
  sync_t sync_y;
  sync_t sync_cb;
  sync_t sync_cr;

  // Products and offsets, one cycle
  csc_products products (
    .clk      (clk),
    .reset    (reset),
    .pixel_in (pixel_in),
    .sync_in  (sync_in),
    .terms_y  (terms_y),
    .terms_cb (terms_cb),
    .terms_cr (terms_cr),
    .sync_q   (sync_q)
  );

  // One adder per output channel, each carries its own copy of sync
  four_input_signed_adder #(.DELAY_DATA_WIDTH(SYNC_W)) adder_y (
    .clk       (clk),
    .reset     (reset),
    .data_1    (terms_y.prod_c0),
    .data_2    (terms_y.prod_c1),
    .data_3    (terms_y.prod_c2),
    .data_4    (terms_y.offset),
    .ddata_in  (sync_q),
    .data_p    (y),
    .ddata_out (sync_y)
  );

  four_input_signed_adder #(.DELAY_DATA_WIDTH(SYNC_W)) adder_cb (
    .clk       (clk),
    .reset     (reset),
    .data_1    (terms_cb.prod_c0),
    .data_2    (terms_cb.prod_c1),
    .data_3    (terms_cb.prod_c2),
    .data_4    (terms_cb.offset),
    .ddata_in  (sync_q),
    .data_p    (cb),
    .ddata_out (sync_cb)
  );

  four_input_signed_adder #(.DELAY_DATA_WIDTH(SYNC_W)) adder_cr (
    .clk       (clk),
    .reset     (reset),
    .data_1    (terms_cr.prod_c0),
    .data_2    (terms_cr.prod_c1),
    .data_3    (terms_cr.prod_c2),
    .data_4    (terms_cr.offset),
    .ddata_in  (sync_q),
    .data_p    (cr),
    .ddata_out (sync_cr)
  );

  // Pack, blank and register
  csc_pixel_out out_stage (
    .clk       (clk),
    .reset     (reset),
    .y         (y),
    .cb        (cb),
    .cr        (cr),
    .sync_y    (sync_y),
    .sync_cb   (sync_cb),
    .sync_cr   (sync_cr),
    .pixel_out (pixel_out),
    .sync_out  (sync_out)
  );

endmodule

`default_nettype wire

//--- test/csc_rgb2ycbcr_tb.sv
// ******************************
// Outputs are expected exactly six cycles after each input
// Reference model wraps the sum to 25 bits before it saturates and truncates
// ******************************
`timescale 1ns/1ps
`default_nettype none

module csc_rgb2ycbcr_tb
  import csc_types_pkg::*;
  import csc_coef_pkg::*;
();

  localparam int          NUM_VEC     = 11;
  localparam int          NUM_RANDOM  = 200;
  localparam int          DRAIN_LIMIT = 50;
  localparam int unsigned SEED        = 46303;

  // One table row holds the stimulus and the expected output pixel
  typedef struct packed {
    pixel_t rgb;
    sync_t  sync;
    pixel_t ycc;
  } vec_t;

  // What the outputs should show six cycles after a drive
  typedef struct packed {
    sync_t  sync;
    pixel_t pix;
  } out_t;

  logic   clk;
  logic   reset;
  pixel_t pixel_in;
  sync_t  sync_in;
  pixel_t pixel_out;
  sync_t  sync_out;

  // BT.601 full range at 4096 scale with rows Y Cb Cr and columns R G B
  int coef_tbl [3][3] = '{
    '{1225, 2404, 467},
    '{-691, -1357, 2048},
    '{2048, -1715, -333}
  };
  int offset_tbl [3] = '{0, 128 << FRAC_BITS, 128 << FRAC_BITS};

  vec_t vec_tbl [NUM_VEC];
  out_t exp_q [$];
  out_t exp_now;

  int error_count = 0;
  int check_count = 0;
  int n_pushed    = 0;
  int n_checked   = 0;

  csc_rgb2ycbcr DUT (
    .clk       (clk),
    .reset     (reset),
    .pixel_in  (pixel_in),
    .sync_in   (sync_in),
    .pixel_out (pixel_out),
    .sync_out  (sync_out)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Signed products plus offset wrapped to 25 bits and then saturated
  function automatic chan_t model_channel(input int row, input pixel_t rgb);
    int          acc;
    logic [24:0] s;
    acc = coef_tbl[row][0] * int'(rgb.c0)
        + coef_tbl[row][1] * int'(rgb.c1)
        + coef_tbl[row][2] * int'(rgb.c2)
        + offset_tbl[row];
    s = acc[24:0];
    // Negative sum
    if (s[24]) begin
      return 8'd0;
    end
    // 256 or more
    if (|s[23:20]) begin
      return 8'd255;
    end
    return s[19:12];
  endfunction

  function automatic pixel_t model_pixel(input pixel_t rgb);
    pixel_t ycc;
    ycc.c0 = model_channel(0, rgb);
    ycc.c1 = model_channel(1, rgb);
    ycc.c2 = model_channel(2, rgb);
    return ycc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error: time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // One pixel per clock with its expected output queued for the scoreboard
  task automatic drive(input pixel_t rgb, input sync_t sync, input pixel_t exp_pix);
    @(posedge clk);
    pixel_in <= rgb;
    sync_in  <= sync;
    exp_q.push_back({sync, exp_pix});
    n_pushed++;
  endtask

  // Each row is R G B then sync as {valid,hsync,vsync} then Y Cb Cr
  task automatic load_table();
    vec_tbl[0]  = {24'h000000, 3'b100, 24'h008080};  // black
    vec_tbl[1]  = {24'hffffff, 3'b100, 24'hff8080};  // white
    vec_tbl[2]  = {24'hff0000, 3'b100, 24'h4c54ff};  // red
    vec_tbl[3]  = {24'h00ff00, 3'b100, 24'h952b15};  // green
    vec_tbl[4]  = {24'h0000ff, 3'b100, 24'h1dff6b};  // blue
    vec_tbl[5]  = {24'h808080, 3'b100, 24'h808080};  // mid grey
    vec_tbl[6]  = {24'hc86432, 3'b100, 24'h7c56b6};
    // Blanking with sync pulses where colour must not leak through
    vec_tbl[7]  = {24'hffffff, 3'b010, 24'h000000};
    vec_tbl[8]  = {24'h123456, 3'b011, 24'h000000};
    vec_tbl[9]  = {24'h804020, 3'b001, 24'h000000};
    // Valid pixel carrying hsync
    vec_tbl[10] = {24'h808080, 3'b110, 24'h808080};
  endtask

  // Scoreboard samples mid cycle where outputs are stable
  always @(negedge clk) begin
    if (exp_q.size() > CSC_LATENCY) begin
      exp_now = exp_q.pop_front();
      check_value("sync_out", exp_now.sync, sync_out);
      check_value("pixel_out", exp_now.pix, pixel_out);
      n_checked++;
    end
  end

  initial begin
    int unsigned seed;
    int          guard;
    int          target;
    logic [31:0] rnd_word;
    pixel_t      rnd_pix;
    sync_t       rnd_sync;

    seed = SEED;
    void'($urandom(seed));

    reset    = 1'b1;
    pixel_in = '0;
    sync_in  = '0;
    load_table();

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Idle right after reset
    @(negedge clk);
    check_value("sync_out", 32'd0, sync_out);
    check_value("pixel_out", 32'd0, pixel_out);
    repeat (10) drive('0, '0, '0);

    // Fixed table driven back to back
    for (int i = 0; i < NUM_VEC; i++) begin
      if (vec_tbl[i].sync.valid) begin
        check_value("model_ycc", vec_tbl[i].ycc, model_pixel(vec_tbl[i].rgb));
      end
      drive(vec_tbl[i].rgb, vec_tbl[i].sync, vec_tbl[i].ycc);
    end
    repeat (3) drive('0, '0, '0);

    // Random valid stream with six pixels in flight
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd_word       = $urandom;
      rnd_pix        = rnd_word[23:0];
      rnd_sync.valid = 1'b1;
      rnd_sync.hsync = rnd_word[24];
      rnd_sync.vsync = rnd_word[25];
      drive(rnd_pix, rnd_sync, model_pixel(rnd_pix));
    end

    // Let the pipeline empty
    target = n_pushed;
    guard  = 0;
    while ((n_checked < target) && (guard < DRAIN_LIMIT)) begin
      drive('0, '0, '0);
      guard++;
    end
    if (n_checked < target) begin
      error_count++;
      $display("timeout: %0d expected outputs never arrived", target - n_checked);
    end

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- csc_rgb2ycbcr.f
hdl/csc_types_pkg.sv
hdl/csc_coef_pkg.sv
hdl/csc_products.sv
hdl/four_input_signed_adder.sv
hdl/csc_pixel_out.sv
hdl/csc_rgb2ycbcr.sv
test/csc_rgb2ycbcr_tb.sv

//--- Bender.yml
package:
  name: csc_rgb2ycbcr

sources:
  - files:
      - hdl/csc_types_pkg.sv
      - hdl/csc_coef_pkg.sv
      - hdl/csc_products.sv
      - hdl/four_input_signed_adder.sv
      - hdl/csc_pixel_out.sv
      - hdl/csc_rgb2ycbcr.sv
  - target: test
    files:
      - test/csc_rgb2ycbcr_tb.sv
